// File: Makefile
TOP := tb_boot_loader

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing --assert -sv -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: compile.f
src/bp_io_pkg.sv
src/bp_cfg_pkg.sv
src/bp_io_credit_counter.sv
src/bp_cfg_loader.sv
src/bp_nbf_loader.sv
src/bp_boot_loader_top.sv
dv/bp_boot_loader_assert.sv
dv/tb_boot_loader.sv

// File: dv/boot_testdata.txt
// one 105-bit word per line: msg type or NBF op (1 bit), addr (40 bits), data (64 bits)
// expected config writes first, then NBF records, then commands expected from the write records
0_0000200008_0000000000000001
0_000020000c_0000000000000000
0_0000200600_0000000000000001
0_0000200204_0000000000000001
0_0000200404_0000000000000001
// NBF records, the last one is the finish record
0_0080000000_0000001300000093
0_0080000008_00000113000001b7
0_0080000010_0010029300a00313
0_0080000018_0000006f00000000
0_0080001000_deadbeefcafef00d
0_0080001008_0123456789abcdef
1_0000000000_0000000000000000
// commands expected from the write records
0_0080000000_0000001300000093
0_0080000008_00000113000001b7
0_0080000010_0010029300a00313
0_0080000018_0000006f00000000
0_0080001000_deadbeefcafef00d
0_0080001008_0123456789abcdef

// File: dv/bp_boot_loader_assert.sv
// boot loader IO checks for command stability, the credit limit and channel ownership
`timescale 1ns/10ps

module bp_boot_loader_assert
  (input  logic                 clk_i
   , input  logic               rst_n_i
   , input  bp_io_pkg::io_msg_s cmd_i
   , input  logic               cmd_v_i
   , input  logic               cmd_yumi_i
   , input  logic               resp_v_i
   , input  logic               resp_ready_i
   , input  logic               cfg_done_i
   , input  logic               nbf_cmd_v_i
   );

   import bp_io_pkg::*;

   logic [io_credit_width:0] in_flight_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         in_flight_r <= '0;
      else
         in_flight_r <= in_flight_r + (cmd_v_i & cmd_yumi_i) - (resp_v_i & resp_ready_i);
   end

   // a presented command holds until taken
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_v_i && !cmd_yumi_i |=> cmd_v_i && $stable(cmd_i))
      else $error("command valid dropped or changed before yumi");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_flight_r <= (io_credit_width + 1)'(io_max_credits))
      else $error("more commands in flight than credits");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !cfg_done_i |-> !nbf_cmd_v_i)
      else $error("NBF command presented before config done");

endmodule

bind bp_boot_loader_top bp_boot_loader_assert i_assert
  (.clk_i(clk_i)
   , .rst_n_i(rst_n_i)
   , .cmd_i(io_cmd_o)
   , .cmd_v_i(io_cmd_v_o)
   , .cmd_yumi_i(io_cmd_yumi_i)
   , .resp_v_i(io_resp_v_i)
   , .resp_ready_i(io_resp_ready_o)
   , .cfg_done_i(cfg_done_o)
   , .nbf_cmd_v_i(nbf_cmd_v_lo)
   );

// File: dv/tb_boot_loader.sv
// testbench for the boot loader, checks config writes and NBF commands against a data file
`timescale 1ns/10ps

module tb_boot_loader;

   import bp_io_pkg::*;
   import bp_cfg_pkg::*;

   typedef logic [$bits(io_msg_s)-1:0] word_t;

   localparam int num_cfg     = 5;
   localparam int num_rec     = 7;
   localparam int num_wr      = 6;
   localparam int num_lines   = num_cfg + num_rec + num_wr;
   localparam int max_cycles  = (num_cfg + num_rec) * 16 + 100;
   localparam int hold_cycles = 32;
   localparam int tail_cycles = 10;

   logic     clk_i = 1'b0;
   logic     rst_n_i;
   io_msg_s  io_cmd_o;
   logic     io_cmd_v_o;
   logic     io_cmd_yumi_i;
   io_msg_s  io_resp_i;
   logic     io_resp_v_i;
   logic     io_resp_ready_o;
   nbf_rec_s nbf_rec_i;
   logic     nbf_v_i;
   logic     nbf_ready_o;
   logic     cfg_done_o;
   logic     nbf_done_o;

   word_t       testdata [num_lines];
   word_t       resp_q [$];
   logic [31:0] lfsr_r;
   int          errors, err_mark, tests_run, tests_failed, cycles;
   int          cmd_count, resp_count, rec_idx, outstanding, max_out;
   int          resp_wait, hold_left, tail_left;
   bit          cfg_seen, nbf_seen, run_done, timed_out;

   always #20 clk_i = ~clk_i;

   bp_boot_loader_top i_dut
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .io_cmd_o(io_cmd_o)
      , .io_cmd_v_o(io_cmd_v_o)
      , .io_cmd_yumi_i(io_cmd_yumi_i)
      , .io_resp_i(io_resp_i)
      , .io_resp_v_i(io_resp_v_i)
      , .io_resp_ready_o(io_resp_ready_o)
      , .nbf_rec_i(nbf_rec_i)
      , .nbf_v_i(nbf_v_i)
      , .nbf_ready_o(nbf_ready_o)
      , .cfg_done_o(cfg_done_o)
      , .nbf_done_o(nbf_done_o)
      );

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output int value);
      value = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_r = next_lfsr(lfsr_r);
         value  = (value << 1) | int'(lfsr_r[0]);
      end
   endtask

   task automatic check_value(input word_t actual, input word_t expected, input string what);
      if (actual !== expected)
      begin
         $display("Fail at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
         errors++;
      end
   endtask

   task automatic finish_test(input int num, input string name);
      tests_run++;
      if (errors == err_mark)
         $display("test %0d %s: ok", num, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // outputs while rst_n_i is low
   task automatic check_reset_outputs();
      check_value(word_t'(io_cmd_v_o), word_t'(0), "io_cmd_v_o in reset");
      check_value(word_t'(io_resp_ready_o), word_t'(1), "io_resp_ready_o in reset");
      check_value(word_t'(nbf_ready_o), word_t'(0), "nbf_ready_o in reset");
      check_value(word_t'(cfg_done_o), word_t'(0), "cfg_done_o in reset");
      check_value(word_t'(nbf_done_o), word_t'(0), "nbf_done_o in reset");
   endtask

   // called 2 ns after the rising edge
   task automatic drive_inputs();
      int stall;
      draw_bits(2, stall);
      io_cmd_yumi_i = io_cmd_v_o && (stall != 0);
      io_resp_v_i   = (resp_q.size() > 0) && (resp_wait == 0) && (hold_left == 0);
      io_resp_i     = (resp_q.size() > 0) ? resp_q[0] : '0;
      nbf_v_i       = (rec_idx < num_rec);
      nbf_rec_i     = (rec_idx < num_rec) ? testdata[num_cfg + rec_idx] : '0;
   endtask

   // called on the falling edge, where every output is settled
   task automatic observe_outputs();
      int delay;
      if (cycles == 0)
      begin
         check_value(word_t'(io_cmd_v_o), word_t'(0), "io_cmd_v_o before first edge");
         check_value(word_t'(io_resp_ready_o), word_t'(1), "io_resp_ready_o after reset");
      end
      if (cycles == 1)
         check_value(word_t'(io_cmd_v_o), word_t'(1), "io_cmd_v_o after first edge");
      if (hold_left > 0)
         hold_left--;
      if (io_cmd_v_o && io_cmd_yumi_i)
      begin
         if (cmd_count < num_cfg)
            check_value(io_cmd_o, testdata[cmd_count], "config write command");
         else if (cmd_count < num_cfg + num_wr)
         begin
            check_value(io_cmd_o, testdata[num_cfg + num_rec + cmd_count - num_cfg],
                        "NBF write command");
            check_value(word_t'(cfg_done_o), word_t'(1), "cfg_done_o during NBF command");
         end
         else
         begin
            $display("unexpected extra command at %0d ns, addr %h", $time, io_cmd_o.addr);
            errors++;
         end
         resp_q.push_back(io_cmd_o);
         cmd_count++;
         outstanding++;
         // hold back responses so the NBF credits fill up
         if (cmd_count == num_cfg + 1)
            hold_left = hold_cycles;
      end
      if (io_resp_v_i && io_resp_ready_o)
      begin
         void'(resp_q.pop_front());
         resp_count++;
         outstanding--;
         draw_bits(3, delay);
         resp_wait = delay;
      end
      else if (resp_wait > 0)
         resp_wait--;
      if (outstanding > max_out)
         max_out = outstanding;
      check_value(word_t'(outstanding <= io_max_credits), word_t'(1), "commands in flight");
      if (nbf_v_i && nbf_ready_o)
         rec_idx++;
      check_value(word_t'(nbf_ready_o && !cfg_done_o), word_t'(0), "nbf_ready_o before cfg_done_o");
      if (cfg_seen)
         check_value(word_t'(cfg_done_o), word_t'(1), "cfg_done_o stays high");
      if (nbf_seen)
         check_value(word_t'(nbf_done_o), word_t'(1), "nbf_done_o stays high");

      if (tests_run == 0 && cmd_count >= num_cfg)
         finish_test(1, "config writes in table order");
      if (tests_run == 1 && cfg_done_o)
      begin
         check_value(word_t'(resp_count), word_t'(num_cfg), "responses at cfg_done_o");
         check_value(word_t'(cmd_count), word_t'(num_cfg), "commands at cfg_done_o");
         cfg_seen = 1'b1;
         finish_test(2, "NBF held off until config done");
      end
      if (tests_run == 2 && cmd_count >= num_cfg + num_wr)
         finish_test(3, "NBF records become commands under yumi stalls");
      if (tests_run == 3 && resp_count >= num_cfg + num_wr)
      begin
         check_value(word_t'(max_out), word_t'(io_max_credits), "credit limit reached");
         finish_test(4, "credit limit with held responses");
      end
      if (nbf_done_o && !nbf_seen)
      begin
         check_value(word_t'(resp_count), word_t'(num_cfg + num_wr), "responses at nbf_done_o");
         check_value(word_t'(outstanding), word_t'(0), "in flight at nbf_done_o");
         check_value(word_t'(rec_idx), word_t'(num_rec), "records taken at nbf_done_o");
         nbf_seen  = 1'b1;
         tail_left = tail_cycles;
      end
      else if (nbf_seen && tail_left > 0)
         tail_left--;
      if (tests_run == 4 && nbf_seen && tail_left == 0)
      begin
         check_value(word_t'(cmd_count), word_t'(num_cfg + num_wr), "commands at end of run");
         finish_test(5, "finish record and done levels");
         run_done = 1'b1;
      end
   endtask

   initial
   begin
      rst_n_i       = 1'b0;
      io_cmd_yumi_i = 1'b0;
      io_resp_i     = '0;
      io_resp_v_i   = 1'b0;
      nbf_rec_i     = '0;
      nbf_v_i       = 1'b0;
      lfsr_r        = 32'd66494;
      $readmemh("dv/boot_testdata.txt", testdata);
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      check_reset_outputs();
      @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      while (!run_done && !timed_out)
      begin
         drive_inputs();
         @(negedge clk_i);
         observe_outputs();
         cycles++;
         timed_out = (cycles >= max_cycles);
         @(posedge clk_i);
         #2;
      end
      $display("summary: %0d tests run, %0d failed, %0d errors, %0d cycles",
               tests_run, tests_failed, errors, cycles);
      if (timed_out)
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
      if (!timed_out && errors == 0 && tests_failed == 0 && tests_run == 5)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: src/bp_boot_loader_top.sv
// boot loader top, runs the config loader then the NBF loader on one shared IO channel
`timescale 1ns/10ps

module bp_boot_loader_top
  (input  logic                   clk_i
   , input  logic                 rst_n_i
   , output bp_io_pkg::io_msg_s   io_cmd_o
   , output logic                 io_cmd_v_o
   , input  logic                 io_cmd_yumi_i
   , input  bp_io_pkg::io_msg_s   io_resp_i
   , input  logic                 io_resp_v_i
   , output logic                 io_resp_ready_o
   , input  bp_cfg_pkg::nbf_rec_s nbf_rec_i
   , input  logic                 nbf_v_i
   , output logic                 nbf_ready_o
   , output logic                 cfg_done_o
   , output logic                 nbf_done_o
   );

   import bp_io_pkg::*;

   io_msg_s cfg_cmd_lo;
   logic    cfg_cmd_v_lo;
   logic    cfg_cmd_yumi_li;
   logic    cfg_resp_v_li;
   logic    cfg_resp_ready_lo;
   logic    cfg_done_lo;

   io_msg_s nbf_cmd_lo;
   logic    nbf_cmd_v_lo;
   logic    nbf_cmd_yumi_li;
   logic    nbf_resp_v_li;
   logic    nbf_resp_ready_lo;
   logic    nbf_ready_lo;
   logic    nbf_done_lo;
   logic    nbf_rst_n;

   // NBF loader stays in reset until configuration is done
   assign nbf_rst_n = rst_n_i & cfg_done_lo;

   bp_cfg_loader i_cfg_loader
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .io_cmd_o(cfg_cmd_lo)
      , .io_cmd_v_o(cfg_cmd_v_lo)
      , .io_cmd_yumi_i(cfg_cmd_yumi_li)
      , .io_resp_v_i(cfg_resp_v_li)
      , .io_resp_ready_o(cfg_resp_ready_lo)
      , .done_o(cfg_done_lo)
      );

   bp_nbf_loader i_nbf_loader
     (.clk_i(clk_i)
      , .rst_n_i(nbf_rst_n)
      , .nbf_rec_i(nbf_rec_i)
      , .nbf_v_i(nbf_v_i & cfg_done_lo)
      , .nbf_ready_o(nbf_ready_lo)
      , .io_cmd_o(nbf_cmd_lo)
      , .io_cmd_v_o(nbf_cmd_v_lo)
      , .io_cmd_yumi_i(nbf_cmd_yumi_li)
      , .io_resp_v_i(nbf_resp_v_li)
      , .io_resp_ready_o(nbf_resp_ready_lo)
      , .done_o(nbf_done_lo)
      );

   // fixed steering, the two loaders never run at the same time
   always_comb
   begin
      if (!cfg_done_lo)
      begin
         io_cmd_o        = cfg_cmd_lo;
         io_cmd_v_o      = cfg_cmd_v_lo;
         io_resp_ready_o = cfg_resp_ready_lo;
         cfg_cmd_yumi_li = io_cmd_yumi_i;
         cfg_resp_v_li   = io_resp_v_i;
         nbf_cmd_yumi_li = 1'b0;
         nbf_resp_v_li   = 1'b0;
      end
      else
      begin
         io_cmd_o        = nbf_cmd_lo;
         io_cmd_v_o      = nbf_cmd_v_lo;
         io_resp_ready_o = nbf_resp_ready_lo;
         cfg_cmd_yumi_li = 1'b0;
         cfg_resp_v_li   = 1'b0;
         nbf_cmd_yumi_li = io_cmd_yumi_i;
         nbf_resp_v_li   = io_resp_v_i;
      end
   end

   // no records taken during configuration
   assign nbf_ready_o = nbf_ready_lo & cfg_done_lo;

   assign cfg_done_o = cfg_done_lo;
   assign nbf_done_o = nbf_done_lo;

endmodule

// File: src/bp_cfg_loader.sv
// configuration loader, writes the boot register table as uncached IO writes
`timescale 1ns/10ps

module bp_cfg_loader
  (input  logic                 clk_i
   , input  logic               rst_n_i
   , output bp_io_pkg::io_msg_s io_cmd_o
   , output logic               io_cmd_v_o
   , input  logic               io_cmd_yumi_i
   , input  logic               io_resp_v_i
   , output logic               io_resp_ready_o
   , output logic               done_o
   );

   import bp_io_pkg::*;
   import bp_cfg_pkg::*;

   logic [cfg_idx_width-1:0] idx_r;
   logic                     table_end;
   cfg_write_s               entry;
   logic                     cmd_xfer;
   logic                     resp_xfer;
   logic                     full_lo;
   logic                     empty_lo;
   logic                     done_r;
   logic                     started_r;

   assign table_end = (idx_r == cfg_idx_width'(cfg_num_writes));

   always_comb
   begin
      entry = '0;
      if (!table_end)
         entry = cfg_boot_table[idx_r];
   end

   // first command one edge after reset, then hold back while all credits are in use
   assign io_cmd_v_o      = started_r & ~table_end & ~full_lo;
   assign io_cmd_o        = '{msg_type: io_uc_wr, addr: entry.addr, data: entry.data};
   assign io_resp_ready_o = 1'b1;

   assign cmd_xfer  = io_cmd_v_o & io_cmd_yumi_i;
   assign resp_xfer = io_resp_v_i & io_resp_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         idx_r     <= '0;
         done_r    <= 1'b0;
         started_r <= 1'b0;
      end
      else
      begin
         started_r <= 1'b1;
         if (cmd_xfer)
            idx_r <= idx_r + 1'b1;
         // all writes issued and acknowledged
         if (table_end && empty_lo)
            done_r <= 1'b1;
      end
   end

   assign done_o = done_r;

   bp_io_credit_counter i_credit_counter
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .inc_i(cmd_xfer)
      , .dec_i(resp_xfer)
      , .full_o(full_lo)
      , .empty_o(empty_lo)
      );

endmodule

// File: src/bp_cfg_pkg.sv
// configuration package with the boot register map, the boot write table and NBF records
package bp_cfg_pkg;

   // config register addresses
   localparam logic [bp_io_pkg::io_addr_width-1:0] cfg_addr_freeze      = 'h20_0008;
   localparam logic [bp_io_pkg::io_addr_width-1:0] cfg_addr_core_id     = 'h20_000c;
   localparam logic [bp_io_pkg::io_addr_width-1:0] cfg_addr_icache_mode = 'h20_0204;
   localparam logic [bp_io_pkg::io_addr_width-1:0] cfg_addr_dcache_mode = 'h20_0404;
   localparam logic [bp_io_pkg::io_addr_width-1:0] cfg_addr_cce_mode    = 'h20_0600;

   // register values written at boot
   localparam logic [bp_io_pkg::io_data_width-1:0] cfg_freeze_on         = 'd1;
   localparam logic [bp_io_pkg::io_data_width-1:0] cfg_core_id_boot      = 'd0;
   localparam logic [bp_io_pkg::io_data_width-1:0] cfg_cce_mode_uncached = 'd1;
   localparam logic [bp_io_pkg::io_data_width-1:0] cfg_cache_mode_normal = 'd1;

   localparam int unsigned cfg_num_writes = 5;

   // table index runs one past the last entry
   localparam int unsigned cfg_idx_width = $clog2(cfg_num_writes + 1);

   typedef struct packed
   {
      logic [bp_io_pkg::io_addr_width-1:0] addr;
      logic [bp_io_pkg::io_data_width-1:0] data;
   } cfg_write_s;

   localparam cfg_write_s cfg_boot_table [cfg_num_writes] = '{
      '{addr: cfg_addr_freeze,      data: cfg_freeze_on},
      '{addr: cfg_addr_core_id,     data: cfg_core_id_boot},
      '{addr: cfg_addr_cce_mode,    data: cfg_cce_mode_uncached},
      '{addr: cfg_addr_icache_mode, data: cfg_cache_mode_normal},
      '{addr: cfg_addr_dcache_mode, data: cfg_cache_mode_normal}
   };

   typedef enum logic [0:0]
   {
      nbf_write  = 1'b0,
      nbf_finish = 1'b1
   } nbf_op_e;

   // one NBF record, 105 bits
   typedef struct packed
   {
      nbf_op_e                             op;
      logic [bp_io_pkg::io_addr_width-1:0] addr;
      logic [bp_io_pkg::io_data_width-1:0] data;
   } nbf_rec_s;

endpackage

// File: src/bp_io_credit_counter.sv
// credit counter, tracks IO commands in flight for one loader and flags full and empty
`timescale 1ns/10ps

module bp_io_credit_counter
  (input  logic   clk_i
   , input  logic rst_n_i
   , input  logic inc_i
   , input  logic dec_i
   , output logic full_o
   , output logic empty_o
   );

   import bp_io_pkg::*;

   logic [io_credit_width-1:0] count_r;

   // a command and a response in the same cycle cancel out
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         count_r <= '0;
      end
      else if (inc_i && !dec_i)
      begin
         count_r <= count_r + 1'b1;
      end
      else if (dec_i && !inc_i)
      begin
         count_r <= count_r - 1'b1;
      end
   end

   assign full_o  = (count_r == io_credit_width'(io_max_credits));
   assign empty_o = (count_r == '0);

endmodule

// File: src/bp_io_pkg.sv
// IO message package with message types, field widths and the per-loader credit limit
package bp_io_pkg;

   // field widths of one IO message
   localparam int unsigned io_addr_width = 40;
   localparam int unsigned io_data_width = 64;

   // commands one loader may have in flight
   localparam int unsigned io_max_credits = 4;

   // wide enough to count 0 through io_max_credits
   localparam int unsigned io_credit_width = $clog2(io_max_credits + 1);

   // uncached write and read
   typedef enum logic [0:0]
   {
      io_uc_wr = 1'b0,
      io_uc_rd = 1'b1
   } io_msg_type_e;

   // one command or response, 105 bits
   typedef struct packed
   {
      io_msg_type_e                msg_type;
      logic [io_addr_width-1:0]    addr;
      logic [io_data_width-1:0]    data;
   } io_msg_s;

endpackage

// File: src/bp_nbf_loader.sv
// NBF loader, turns NBF write records into IO commands and finishes at the finish record
`timescale 1ns/10ps

module bp_nbf_loader
  (input  logic                   clk_i
   , input  logic                 rst_n_i
   , input  bp_cfg_pkg::nbf_rec_s nbf_rec_i
   , input  logic                 nbf_v_i
   , output logic                 nbf_ready_o
   , output bp_io_pkg::io_msg_s   io_cmd_o
   , output logic                 io_cmd_v_o
   , input  logic                 io_cmd_yumi_i
   , input  logic                 io_resp_v_i
   , output logic                 io_resp_ready_o
   , output logic                 done_o
   );

   import bp_io_pkg::*;
   import bp_cfg_pkg::*;

   io_msg_s cmd_r;
   logic    pending_r;
   logic    finishing_r;
   logic    done_r;
   logic    rec_wr;
   logic    rec_fin;
   logic    cmd_xfer;
   logic    resp_xfer;
   logic    full_lo;
   logic    empty_lo;

   // one command slot, no new records once finishing
   assign nbf_ready_o = ~pending_r & ~full_lo & ~finishing_r;

   assign rec_wr    = nbf_v_i & nbf_ready_o & (nbf_rec_i.op == nbf_write);
   assign rec_fin   = nbf_v_i & nbf_ready_o & (nbf_rec_i.op == nbf_finish);
   assign cmd_xfer  = pending_r & io_cmd_yumi_i;
   assign resp_xfer = io_resp_v_i & io_resp_ready_o;

   assign io_cmd_v_o      = pending_r;
   assign io_cmd_o        = cmd_r;
   assign io_resp_ready_o = 1'b1;
   assign done_o          = done_r;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         pending_r   <= 1'b0;
         finishing_r <= 1'b0;
         done_r      <= 1'b0;
      end
      else
      begin
         if (rec_wr)
            pending_r <= 1'b1;
         else if (cmd_xfer)
            pending_r <= 1'b0;
         if (rec_fin)
            finishing_r <= 1'b1;
         // finish seen and every response back
         if (finishing_r && empty_lo && !pending_r)
            done_r <= 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rec_wr)
         cmd_r <= '{msg_type: io_uc_wr, addr: nbf_rec_i.addr, data: nbf_rec_i.data};
   end

   bp_io_credit_counter i_credit_counter
     (.clk_i(clk_i)
      , .rst_n_i(rst_n_i)
      , .inc_i(cmd_xfer)
      , .dec_i(resp_xfer)
      , .full_o(full_lo)
      , .empty_o(empty_lo)
      );

endmodule
